/* logic/buffet_settings.svh */
// Width, storage depth and scoreboard depth macros for the buffet control block
`ifndef BUFFET_SETTINGS_SVH
`define BUFFET_SETTINGS_SVH

// --------------------
// Storage geometry
// --------------------

// Index into the storage and the width of a read offset
`define BUFFET_ADDR_WIDTH 8

// One data word as pushed and updated
`define BUFFET_DATA_WIDTH 32

// Storage entries as a power of two so indices wrap for free
`define BUFFET_SIZE (1 << `BUFFET_ADDR_WIDTH)

// --------------------
// Hazard tracking
// --------------------

// Outstanding will-update reads that can be tracked at once
`define BUFFET_SB_SIZE 8

`endif

/* logic/buffet_pkg.sv */
// Vector typedefs and the read state enum shared by the buffet control blocks
`include "buffet_settings.svh"

package buffet_pkg;

    // Index or offset into the storage that wraps modulo the storage size
    typedef logic [`BUFFET_ADDR_WIDTH-1:0] idx_t;

    // Head or tail pointer with one wrap bit on top
    // Also holds occupancy and free space from 0 up to the storage size
    typedef logic [`BUFFET_ADDR_WIDTH:0] ptr_t;

    // Data word
    typedef logic [`BUFFET_DATA_WIDTH-1:0] data_t;

    // Number of one scoreboard entry
    typedef logic [$clog2(`BUFFET_SB_SIZE)-1:0] sb_slot_t;

    // Read side states
    typedef enum logic [1:0] {
        IDLE,
        HOLD,
        ISSUE
    } read_state_e;

endpackage

/* logic/buffet_sb_if.sv */
// Interface between the read state machine and the scoreboard, with its modports
`timescale 1ns/100ps

interface buffet_sb_if import buffet_pkg::*; ();

    // Index of the read currently held by the state machine
    idx_t lookup_idx;

    // A valid entry matches lookup_idx
    logic raw_hazard;

    // Every entry valid so there is no room for another will-update read
    logic full;

    // Single-cycle pulse that records alloc_idx on the same edge
    logic alloc;
    idx_t alloc_idx;

    // --------------------
    // Modports
    // --------------------

    // Read FSM side
    modport reader (
        output lookup_idx,
        output alloc,
        output alloc_idx,
        input  raw_hazard,
        input  full
    );

    // Scoreboard side
    modport sb_table (
        input  lookup_idx,
        input  alloc,
        input  alloc_idx,
        output raw_hazard,
        output full
    );

endinterface

/* logic/buffet_window.sv */
// Head and tail pointers, occupancy, credit reply, push output and the window check
`timescale 1ns/100ps
`include "buffet_settings.svh"

module buffet_window import buffet_pkg::*; (
    input  logic  clk,
    input  logic  nreset_i,
    // Producer push
    input  logic  push_data_valid_i,
    input  data_t push_data_i,
    output logic  push_data_valid_o,
    output data_t push_data_o,
    output idx_t  push_idx_o,
    // Credit request and reply
    input  logic  credit_ready_i,
    output logic  credit_valid_o,
    output ptr_t  credit_o,
    // Read offset and shrink amount
    input  idx_t  read_idx_i,
    input  logic  shrink_accept_i,
    output idx_t  read_abs_idx_o,
    // Window check for the held read
    input  idx_t  held_idx_i,
    output logic  held_in_window_o
);

    // Pointers carry a wrap bit so full and empty differ
    ptr_t tail;
    ptr_t head;
    ptr_t tail_next;
    ptr_t head_next;
    ptr_t occupancy;
    ptr_t free_space;
    ptr_t free_next;
    idx_t held_offset;

    // --------------------
    // Occupancy
    // --------------------

    assign occupancy  = tail - head;
    assign free_space = ptr_t'(`BUFFET_SIZE) - occupancy;

    // Pointer values after this edge
    assign tail_next = push_data_valid_i ? tail + ptr_t'(1) : tail;
    assign head_next = shrink_accept_i ? head + ptr_t'(read_idx_i) : head;

    // Credit reflects the push and shrink of the same edge
    assign free_next = ptr_t'(`BUFFET_SIZE) - (tail_next - head_next);

    // --------------------
    // Read window
    // --------------------

    // Offsets count from the head
    assign read_abs_idx_o = read_idx_i + head[`BUFFET_ADDR_WIDTH-1:0];

    // Distance of the held index from the head wrapping with the storage
    assign held_offset = held_idx_i - head[`BUFFET_ADDR_WIDTH-1:0];

    // Already pushed when closer to the head than the tail is
    assign held_in_window_o = ptr_t'(held_offset) < occupancy;

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            tail              <= '0;
            head              <= '0;
            push_data_valid_o <= 1'b0;
            credit_valid_o    <= 1'b0;
        end else begin
            tail              <= tail_next;
            head              <= head_next;
            push_data_valid_o <= push_data_valid_i;
            credit_valid_o    <= credit_ready_i;
        end
    end

    // Push goes to storage at the old tail
    always_ff @(posedge clk) begin
        if (push_data_valid_i) begin
            push_data_o <= push_data_i;
            push_idx_o  <= tail[`BUFFET_ADDR_WIDTH-1:0];
        end
        if (credit_ready_i) begin
            credit_o <= free_next;
        end
    end

    // --------------------
    // Checks
    // --------------------

    // The FSM never frees more than has been pushed
    shrink_in_range: assert property (
        @(posedge clk) disable iff (!nreset_i)
        shrink_accept_i |-> (ptr_t'(read_idx_i) <= occupancy)
    ) else $error("Shrink of %0d exceeds occupancy %0d", read_idx_i, occupancy);

    // Producer stays within its credits
    push_has_space: assert property (
        @(posedge clk) disable iff (!nreset_i)
        push_data_valid_i |-> (free_space != '0)
    ) else $error("Push into a full window");

endmodule

/* logic/buffet_read_fsm.sv */
// Read FSM that holds one read until its hazards clear and then dispatches it
`timescale 1ns/100ps

module buffet_read_fsm import buffet_pkg::*; (
    input  logic  clk,
    input  logic  nreset_i,
    // Consumer read request
    input  logic  read_idx_valid_i,
    input  logic  read_is_shrink_i,
    input  logic  read_will_update_i,
    input  logic  read_data_ready_i,
    output logic  read_idx_ready_o,
    // From and to the window
    input  idx_t  read_abs_idx_i,
    input  logic  held_in_window_i,
    output logic  shrink_accept_o,
    output idx_t  held_idx_o,
    // Dispatch to storage
    output logic  read_idx_valid_o,
    output idx_t  read_idx_o,
    // Scoreboard lookup and allocation
    buffet_sb_if.reader sb
);

    read_state_e state;

    // The one read in flight
    idx_t held_idx;
    logic held_will_update;

    logic accept;
    logic stall;

    // --------------------
    // Handshake
    // --------------------

    // Only one read at a time so ready means idle
    assign read_idx_ready_o = (state == IDLE);

    assign accept          = read_idx_valid_i & read_idx_ready_o & ~read_is_shrink_i;
    assign shrink_accept_o = read_idx_valid_i & read_idx_ready_o & read_is_shrink_i;

    // Reasons to keep holding
    // WAR when not yet pushed, RAW on an outstanding update,
    // consumer back-pressure, or no room to track a will-update read
    assign stall = ~held_in_window_i
                 | sb.raw_hazard
                 | ~read_data_ready_i
                 | (held_will_update & sb.full);

    // --------------------
    // Scoreboard side
    // --------------------

    assign sb.lookup_idx = held_idx;
    assign sb.alloc_idx  = held_idx;

    // Record the index on the edge that leaves HOLD
    assign sb.alloc = (state == HOLD) & ~stall & held_will_update;

    // --------------------
    // Outputs
    // --------------------

    assign held_idx_o       = held_idx;
    assign read_idx_valid_o = (state == ISSUE);
    assign read_idx_o       = held_idx;

    // --------------------
    // State register
    // --------------------

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                // Wait for an accepted read
                IDLE: begin
                    if (accept) begin
                        state <= HOLD;
                    end
                end
                // Hazards checked every cycle
                HOLD: begin
                    if (!stall) begin
                        state <= ISSUE;
                    end
                end
                // Single dispatch cycle
                ISSUE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Absolute index taken while the head is still the one the offset referred to
    always_ff @(posedge clk) begin
        if (accept) begin
            held_idx         <= read_abs_idx_i;
            held_will_update <= read_will_update_i;
        end
    end

    // --------------------
    // Checks
    // --------------------

    // A dispatched read has already been pushed and the head has not moved past it
    dispatch_in_window: assert property (
        @(posedge clk) disable iff (!nreset_i)
        read_idx_valid_o |-> held_in_window_i
    ) else $error("Read dispatched outside the window");

endmodule

/* logic/buffet_scoreboard.sv */
// Scoreboard of outstanding update indices and the update forwarding path that clears it
`timescale 1ns/100ps
`include "buffet_settings.svh"

module buffet_scoreboard import buffet_pkg::*; (
    input  logic  clk,
    input  logic  nreset_i,
    // Update from the consumer
    input  logic  update_valid_i,
    input  idx_t  update_idx_i,
    input  data_t update_data_i,
    // Update forwarded to storage
    output logic  update_valid_o,
    output idx_t  update_idx_o,
    output data_t update_data_o,
    // Lookup and allocation from the read FSM
    buffet_sb_if.sb_table sb
);

    // Tracked indices and their valid bits
    idx_t                       entry_idx [`BUFFET_SB_SIZE];
    logic [`BUFFET_SB_SIZE-1:0] entry_valid;

    // Per-entry compare results
    logic [`BUFFET_SB_SIZE-1:0] match_lookup;
    logic [`BUFFET_SB_SIZE-1:0] match_update;

    sb_slot_t free_slot;
    sb_slot_t clear_slot;

    // First forwarding stage
    logic upd_valid_r;
    idx_t upd_idx_r;

    // Lowest set bit of a slot vector or 0 when none
    function automatic sb_slot_t lowest_set(input logic [`BUFFET_SB_SIZE-1:0] vec);
        sb_slot_t slot;
        slot = '0;
        // Walk down so the lowest hit is the last one written
        for (int i = `BUFFET_SB_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                slot = sb_slot_t'(i);
            end
        end
        return slot;
    endfunction

    // --------------------
    // Compare
    // --------------------

    always_comb begin
        for (int i = 0; i < `BUFFET_SB_SIZE; i++) begin
            match_lookup[i] = entry_valid[i] && (entry_idx[i] == sb.lookup_idx);
            match_update[i] = entry_valid[i] && (entry_idx[i] == upd_idx_r);
        end
    end

    assign sb.raw_hazard = |match_lookup;
    assign sb.full       = &entry_valid;

    // Allocation fills from the bottom; duplicates clear one at a time
    assign free_slot  = lowest_set(~entry_valid);
    assign clear_slot = lowest_set(match_update);

    // --------------------
    // Table
    // --------------------

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            entry_valid <= '0;
        end else begin
            if (sb.alloc) begin
                entry_valid[free_slot] <= 1'b1;
            end
            // Registered update retires its entry
            if (upd_valid_r && (|match_update)) begin
                entry_valid[clear_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sb.alloc) begin
            entry_idx[free_slot] <= sb.alloc_idx;
        end
    end

    // --------------------
    // Update forwarding
    // --------------------

    always_ff @(posedge clk or negedge nreset_i) begin
        if (!nreset_i) begin
            upd_valid_r    <= 1'b0;
            update_valid_o <= 1'b0;
        end else begin
            upd_valid_r    <= update_valid_i;
            update_valid_o <= upd_valid_r;
        end
    end

    // Data trails the index by one cycle
    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            upd_idx_r <= update_idx_i;
        end
        if (upd_valid_r) begin
            update_idx_o  <= upd_idx_r;
            update_data_o <= update_data_i;
        end
    end

    // --------------------
    // Checks
    // --------------------

    // The FSM holds a will-update read while the table is full
    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!nreset_i)
        sb.alloc |-> !sb.full
    ) else $error("Scoreboard allocation while full");

endmodule

/* logic/buffet_control.sv */
// Buffet control top level wiring the window, read FSM and scoreboard to plain ports
`timescale 1ns/100ps

module buffet_control import buffet_pkg::*; (
    input  logic  clk,
    input  logic  nreset_i,
    // --------------------
    // Read
    // --------------------
    input  idx_t  read_idx_i,
    input  logic  read_idx_valid_i,
    input  logic  read_is_shrink_i,
    input  logic  read_will_update_i,
    input  logic  read_data_ready_i,
    output logic  read_idx_ready_o,
    output logic  read_idx_valid_o,
    output idx_t  read_idx_o,
    // --------------------
    // Push
    // --------------------
    input  logic  push_data_valid_i,
    input  data_t push_data_i,
    output logic  push_data_valid_o,
    output data_t push_data_o,
    output idx_t  push_idx_o,
    // --------------------
    // Update
    // --------------------
    input  logic  update_valid_i,
    input  idx_t  update_idx_i,
    input  data_t update_data_i,
    output logic  update_valid_o,
    output idx_t  update_idx_o,
    output data_t update_data_o,
    // --------------------
    // Credit
    // --------------------
    input  logic  credit_ready_i,
    output logic  credit_valid_o,
    output ptr_t  credit_o
);

    // Window to FSM
    idx_t read_abs_idx;
    logic held_in_window;

    // FSM to window
    idx_t held_idx;
    logic shrink_accept;

    // Read FSM to scoreboard
    buffet_sb_if sb_if_i ();

    // Pointers, credits and push path
    buffet_window window_i (
        .clk               (clk),
        .nreset_i          (nreset_i),
        .push_data_valid_i (push_data_valid_i),
        .push_data_i       (push_data_i),
        .push_data_valid_o (push_data_valid_o),
        .push_data_o       (push_data_o),
        .push_idx_o        (push_idx_o),
        .credit_ready_i    (credit_ready_i),
        .credit_valid_o    (credit_valid_o),
        .credit_o          (credit_o),
        .read_idx_i        (read_idx_i),
        .shrink_accept_i   (shrink_accept),
        .read_abs_idx_o    (read_abs_idx),
        .held_idx_i        (held_idx),
        .held_in_window_o  (held_in_window)
    );

    // Single read in flight
    buffet_read_fsm read_fsm_i (
        .clk                (clk),
        .nreset_i           (nreset_i),
        .read_idx_valid_i   (read_idx_valid_i),
        .read_is_shrink_i   (read_is_shrink_i),
        .read_will_update_i (read_will_update_i),
        .read_data_ready_i  (read_data_ready_i),
        .read_idx_ready_o   (read_idx_ready_o),
        .read_abs_idx_i     (read_abs_idx),
        .held_in_window_i   (held_in_window),
        .shrink_accept_o    (shrink_accept),
        .held_idx_o         (held_idx),
        .read_idx_valid_o   (read_idx_valid_o),
        .read_idx_o         (read_idx_o),
        .sb                 (sb_if_i)
    );

    // Outstanding updates and forwarding
    buffet_scoreboard scoreboard_i (
        .clk            (clk),
        .nreset_i       (nreset_i),
        .update_valid_i (update_valid_i),
        .update_idx_i   (update_idx_i),
        .update_data_i  (update_data_i),
        .update_valid_o (update_valid_o),
        .update_idx_o   (update_idx_o),
        .update_data_o  (update_data_o),
        .sb             (sb_if_i)
    );

endmodule

/* dv/buffet_tb.sv */
// Buffet control testbench with clock, reset, LFSR stimulus, reference model and checks
`timescale 1ns/100ps
`include "buffet_settings.svh"

module buffet_tb import buffet_pkg::*; ();

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int          WAIT_LIMIT = 64;

    // DUT ports
    logic  clk;
    logic  nreset_i;
    idx_t  read_idx_i;
    logic  read_idx_valid_i;
    logic  read_is_shrink_i;
    logic  read_will_update_i;
    logic  read_data_ready_i;
    logic  read_idx_ready_o;
    logic  read_idx_valid_o;
    idx_t  read_idx_o;
    logic  push_data_valid_i;
    logic  push_data_valid_o;
    data_t push_data_i;
    data_t push_data_o;
    idx_t  push_idx_o;
    logic  update_valid_i;
    logic  update_valid_o;
    idx_t  update_idx_i;
    idx_t  update_idx_o;
    data_t update_data_i;
    data_t update_data_o;
    logic  credit_ready_i;
    logic  credit_valid_o;
    ptr_t  credit_o;

    // Reference model
    // Head and tail count pushes and shrinks without wrapping
    logic [31:0] lfsr;
    int          model_head;
    int          model_tail;
    idx_t        pending_updates [$];
    idx_t        dispatched [$];

    // Report counters
    int test_errors;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    buffet_control buffet_control_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Dispatch pulses taken mid-cycle
    always @(negedge clk) begin
        if (nreset_i && read_idx_valid_o) begin
            dispatched.push_back(read_idx_o);
        end
    end

    // --------------------
    // Helpers
    // --------------------

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? LFSR_TAPS : 32'h0);
            value   = {value[30:0], bit_out};
        end
        return value;
    endfunction

    function automatic int occupancy();
        return model_tail - model_head;
    endfunction

    function automatic logic is_pending(input idx_t idx);
        foreach (pending_updates[i]) begin
            if (pending_updates[i] == idx) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string title);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", title);
        end else begin
            $display("%s: %0d errors", title, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // --------------------
    // Bus tasks
    // --------------------

    // One push and/or credit request checked on the cycle after the sampling edge
    task automatic push_and_credit(input logic do_push, input data_t data, input logic do_credit);
        @(posedge clk);
        push_data_valid_i <= do_push;
        push_data_i       <= data;
        credit_ready_i    <= do_credit;
        @(posedge clk);
        push_data_valid_i <= 1'b0;
        credit_ready_i    <= 1'b0;
        @(negedge clk);
        compare("push_data_valid_o", 32'(push_data_valid_o), 32'(do_push));
        if (do_push) begin
            compare("push_idx_o", 32'(push_idx_o), 32'(model_tail % `BUFFET_SIZE));
            compare("push_data_o", push_data_o, data);
            model_tail++;
        end
        compare("credit_valid_o", 32'(credit_valid_o), 32'(do_credit));
        // Reply counts the push of the same edge
        if (do_credit) begin
            compare("credit_o", 32'(credit_o), 32'(`BUFFET_SIZE - occupancy()));
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (read_idx_ready_o !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (read_idx_ready_o !== 1'b1) begin
            $display("Timeout: read side never became ready again");
            test_errors++;
        end
    endtask

    task automatic shrink_by(input int amount);
        wait_ready();
        @(posedge clk);
        read_idx_valid_i <= 1'b1;
        read_is_shrink_i <= 1'b1;
        read_idx_i       <= idx_t'(amount);
        @(posedge clk);
        read_idx_valid_i <= 1'b0;
        read_is_shrink_i <= 1'b0;
        model_head += amount;
    endtask

    // Absolute index is head plus offset at acceptance
    task automatic issue_read(input int offset, input logic will_update, output idx_t abs_idx);
        wait_ready();
        @(posedge clk);
        read_idx_valid_i   <= 1'b1;
        read_idx_i         <= idx_t'(offset);
        read_will_update_i <= will_update;
        @(posedge clk);
        read_idx_valid_i   <= 1'b0;
        read_will_update_i <= 1'b0;
        abs_idx = idx_t'(model_head + offset);
    endtask

    task automatic expect_dispatch(input idx_t expected);
        int cycles;
        cycles = 0;
        while (dispatched.size() == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (dispatched.size() == 0) begin
            $display("Timeout: a held read was never dispatched");
            test_errors++;
        end else begin
            compare("read_idx_o", 32'(dispatched.pop_front()), 32'(expected));
            // A second pulse for the same read would show up here
            repeat (2) @(posedge clk);
            compare("read_idx_valid_o pulses", 32'(dispatched.size()), 32'd0);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        compare("read_idx_valid_o pulses", 32'(dispatched.size()), 32'd0);
    endtask

    // Data follows the index by one cycle and the output comes two edges after sampling
    task automatic send_update(input idx_t idx, input data_t data);
        @(posedge clk);
        update_valid_i <= 1'b1;
        update_idx_i   <= idx;
        @(posedge clk);
        update_valid_i <= 1'b0;
        update_data_i  <= data;
        @(negedge clk);
        compare("update_valid_o", 32'(update_valid_o), 32'd0);
        @(negedge clk);
        compare("update_valid_o", 32'(update_valid_o), 32'd1);
        compare("update_idx_o", 32'(update_idx_o), 32'(idx));
        compare("update_data_o", update_data_o, data);
        for (int i = 0; i < pending_updates.size(); i++) begin
            if (pending_updates[i] == idx) begin
                pending_updates.delete(i);
                break;
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int    offset;
        idx_t  abs_idx;
        idx_t  upd_idx;
        logic  hold_back;
        lfsr               = 32'hd58b;
        model_head         = 0;
        model_tail         = 0;
        test_errors        = 0;
        errors             = 0;
        checks             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        nreset_i           = 1'b0;
        read_idx_i         = '0;
        read_idx_valid_i   = 1'b0;
        read_is_shrink_i   = 1'b0;
        read_will_update_i = 1'b0;
        read_data_ready_i  = 1'b1;
        push_data_valid_i  = 1'b0;
        push_data_i        = '0;
        update_valid_i     = 1'b0;
        update_idx_i       = '0;
        update_data_i      = '0;
        credit_ready_i     = 1'b0;
        repeat (16) @(posedge clk);
        nreset_i <= 1'b1;

        // Reset state and an empty window
        @(negedge clk);
        compare("push_data_valid_o", 32'(push_data_valid_o), 32'd0);
        compare("credit_valid_o", 32'(credit_valid_o), 32'd0);
        compare("update_valid_o", 32'(update_valid_o), 32'd0);
        compare("read_idx_valid_o", 32'(read_idx_valid_o), 32'd0);
        compare("read_idx_ready_o", 32'(read_idx_ready_o), 32'd1);
        push_and_credit(1'b0, '0, 1'b1);
        finish_test("Test 1 reset state");

        for (int n = 0; n < 40; n++) begin
            push_and_credit(1'b1, rand_bits(32), 1'b0);
        end
        finish_test("Test 2 push index and data");

        // Mixed pushes and shrinks with enough pushes for the index to wrap
        for (int n = 0; n < 500; n++) begin
            if (rand_bits(1) != 0 && occupancy() < `BUFFET_SIZE) begin
                push_and_credit(1'b1, rand_bits(32), rand_bits(1) != 0);
            end else begin
                shrink_by(int'(rand_bits(4) % (occupancy() + 1)));
                push_and_credit(1'b0, '0, 1'b1);
            end
        end
        finish_test("Test 3 credit after push and shrink");

        for (int n = 0; n < 24; n++) begin
            push_and_credit(1'b1, rand_bits(32), 1'b0);
        end
        for (int n = 0; n < 12; n++) begin
            offset    = int'(rand_bits(8) % occupancy());
            hold_back = rand_bits(1) != 0;
            @(posedge clk);
            read_data_ready_i <= ~hold_back;
            issue_read(offset, 1'b0, abs_idx);
            if (hold_back) begin
                expect_quiet(4 + int'(rand_bits(3)));
                @(posedge clk);
                read_data_ready_i <= 1'b1;
            end
            expect_dispatch(abs_idx);
        end
        finish_test("Test 4 reads inside the window");

        // Read past the tail waits for the pushes that reach it
        for (int n = 0; n < 4; n++) begin
            offset = occupancy() + int'(rand_bits(2));
            issue_read(offset, 1'b0, abs_idx);
            while (offset >= occupancy()) begin
                compare("read_idx_valid_o pulses", 32'(dispatched.size()), 32'd0);
                push_and_credit(1'b1, rand_bits(32), 1'b0);
            end
            expect_dispatch(abs_idx);
        end
        finish_test("Test 5 read beyond the tail");

        for (int n = 0; n < 6; n++) begin
            offset = int'(rand_bits(8) % occupancy());
            issue_read(offset, 1'b1, upd_idx);
            expect_dispatch(upd_idx);
            pending_updates.push_back(upd_idx);
            // About half of the second reads move to another offset
            if (rand_bits(1) != 0) begin
                offset = int'(rand_bits(8) % occupancy());
            end
            issue_read(offset, 1'b0, abs_idx);
            if (is_pending(abs_idx)) begin
                expect_quiet(8);
                send_update(upd_idx, rand_bits(32));
                expect_dispatch(abs_idx);
            end else begin
                expect_dispatch(abs_idx);
                send_update(upd_idx, rand_bits(32));
            end
        end
        finish_test("Test 6 read after update hazard");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/buffet_pkg.sv
logic/buffet_sb_if.sv
logic/buffet_window.sv
logic/buffet_read_fsm.sv
logic/buffet_scoreboard.sv
logic/buffet_control.sv
dv/buffet_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the buffet control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module buffet_tb \
    -Mdir build/obj_dir -o buffet_sim

./build/obj_dir/buffet_sim > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q "Regression failed" build/sim.log || ! grep -q "Regression passed" build/sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation clean"
